/* include/bootLoader_consts.svh */
`ifndef BOOTLOADER_CONSTS_SVH
`define BOOTLOADER_CONSTS_SVH

// serial timing
// 27 MHz system clock over 115200 baud gives 234 cycles per bit
`define CLKS_PER_BIT 234

// instruction store
// word count of the instruction memory, fits a 7-bit index
`define MEM_DEPTH 128

// fetch side
// addi x0, x0, 0 in RV32I, handed out for any address past the store
`define NOP_INSTR 32'h0000_0013

`endif

/* source/bootLoaderPkg.sv */
`default_nettype none

package bootLoaderPkg;

    // one byte as it comes off the serial line
    typedef logic [7:0] byteT;

    // one instruction word, assembled big-endian from four bytes
    typedef logic [31:0] instrT;

    // word address seen on the fetch bus, upper half is outside the store
    typedef logic [7:0] busAdrT;

    // index into the instruction store
    typedef logic [6:0] memIdxT;

    // receiver frame states
    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxData,
        rxStop
    } rxStateT;

    // loader states: length byte, program bytes, finished
    typedef enum logic [1:0] {
        loadSize,
        loadByte,
        loadDone
    } loadStateT;

endpackage

`default_nettype wire

/* source/uartRx.sv */
`default_nettype none
`include "bootLoader_consts.svh"

module uartRx (
    input  wire logic           clk,
    input  wire logic           arstN,
    input  wire logic           rxSerial,
    output bootLoaderPkg::byteT rxByte,
    output logic                rxValid
);
    import bootLoaderPkg::*;

    localparam int HalfBit = `CLKS_PER_BIT / 2;
    localparam int CntW = $clog2(`CLKS_PER_BIT);

    logic            rxMeta;
    logic            rxSync;
    logic            rxPrev;
    logic            fallEdge;
    logic            halfDone;
    logic            bitDone;
    rxStateT         rxState;
    logic [CntW-1:0] bitCnt;
    logic [2:0]      bitIdx;

    // line idles high, so the synchronizer comes out of reset at 1
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= rxSerial;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    assign fallEdge = rxPrev && !rxSync;
    assign halfDone = (bitCnt == CntW'(HalfBit - 1));
    assign bitDone  = (bitCnt == CntW'(`CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxState <= rxIdle;
            bitCnt  <= '0;
            bitIdx  <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            case (rxState)
                rxIdle: begin
                    bitCnt <= '0;
                    if (fallEdge) begin
                        rxState <= rxStart;
                    end
                end
                rxStart: begin
                    if (halfDone) begin
                        bitCnt <= '0;
                        bitIdx <= '0;
                        // line back high at mid start bit, treat as a glitch
                        if (rxSync) begin
                            rxState <= rxIdle;
                        end else begin
                            rxState <= rxData;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                rxData: begin
                    if (bitDone) begin
                        bitCnt <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == 3'd7) begin
                            rxState <= rxStop;
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                rxStop: begin
                    if (bitDone) begin
                        // framing error drops the byte silently
                        rxValid <= rxSync;
                        rxState <= rxIdle;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: begin
                    rxState <= rxIdle;
                end
            endcase
        end
    end

    // lsb first, so each new bit enters at the top
    always_ff @(posedge clk) begin
        if (rxState == rxData && bitDone) begin
            rxByte <= {rxSync, rxByte[7:1]};
        end
    end

endmodule

`default_nettype wire

/* source/programLoader.sv */
`default_nettype none

module programLoader (
    input  wire logic                  clk,
    input  wire logic                  arstN,
    input  wire bootLoaderPkg::byteT   rxByte,
    input  wire logic                  rxValid,
    output logic                       memWe,
    output bootLoaderPkg::memIdxT      memWrIdx,
    output bootLoaderPkg::instrT       memWrData,
    output logic                       cpuEnable
);
    import bootLoaderPkg::*;

    loadStateT                  loadState;
    byteT                       loadLen;
    // one bit wider than the index so a full store can be counted
    logic [$bits(memIdxT):0]    wordCnt;
    logic [1:0]                 byteCnt;
    logic                       byteIn;
    logic                       wordDone;

    assign byteIn   = rxValid && (loadState == loadByte);
    assign wordDone = byteIn && (byteCnt == 2'd3);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loadState <= loadSize;
            loadLen   <= '0;
            wordCnt   <= '0;
            byteCnt   <= '0;
            memWe     <= 1'b0;
            cpuEnable <= 1'b0;
        end else begin
            memWe <= wordDone;
            // index moves on once the write has gone out
            if (memWe) begin
                wordCnt <= wordCnt + 1'b1;
            end
            case (loadState)
                loadSize: begin
                    if (rxValid) begin
                        loadLen   <= rxByte;
                        byteCnt   <= '0;
                        loadState <= loadByte;
                    end
                end
                loadByte: begin
                    if (rxValid) begin
                        byteCnt <= byteCnt + 1'b1;
                    end
                    if (wordDone && (byteT'(wordCnt + 1'b1) == loadLen)) begin
                        loadState <= loadDone;
                        cpuEnable <= 1'b1;
                    end
                end
                loadDone: begin
                    // program complete so later bytes are dropped
                end
                default: begin
                    loadState <= loadSize;
                end
            endcase
        end
    end

    // big-endian packing puts the first byte in bits 31:24
    always_ff @(posedge clk) begin
        if (byteIn) begin
            memWrData <= {memWrData[23:0], rxByte};
        end
    end

    assign memWrIdx = wordCnt[$bits(memIdxT)-1:0];

endmodule

`default_nettype wire

/* source/instrMem.sv */
`default_nettype none
`include "bootLoader_consts.svh"

module instrMem (
    input  wire logic                   clk,
    input  wire logic                   memWe,
    input  wire bootLoaderPkg::memIdxT  memWrIdx,
    input  wire bootLoaderPkg::instrT   memWrData,
    input  wire bootLoaderPkg::memIdxT  memRdIdx,
    output bootLoaderPkg::instrT        memRdData
);
    import bootLoaderPkg::*;

    instrT memArray [`MEM_DEPTH];

    // single write port fed by the loader
    always_ff @(posedge clk) begin
        if (memWe) begin
            memArray[memWrIdx] <= memWrData;
        end
    end

    // registered read, one cycle from index to data
    always_ff @(posedge clk) begin
        memRdData <= memArray[memRdIdx];
    end

endmodule

`default_nettype wire

/* source/instrBusSlave.sv */
`default_nettype none
`include "bootLoader_consts.svh"

module instrBusSlave (
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic                   wbCyc,
    input  wire logic                   wbStb,
    input  wire bootLoaderPkg::busAdrT  wbAdr,
    output bootLoaderPkg::instrT        wbDatOut,
    output logic                        wbAck,
    output bootLoaderPkg::memIdxT       memRdIdx,
    input  wire bootLoaderPkg::instrT   memRdData
);
    import bootLoaderPkg::*;

    logic reqStart;
    logic reqPend;
    logic outOfRange;

    // memory sees the address directly, its read register is the first stage
    assign memRdIdx = wbAdr[$bits(memIdxT)-1:0];

    // new request only when nothing is in flight or being acked
    assign reqStart = wbCyc && wbStb && !reqPend && !wbAck;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqPend <= 1'b0;
            wbAck   <= 1'b0;
        end else begin
            reqPend <= reqStart;
            // abandoned cycle gets no ack
            wbAck   <= reqPend && wbCyc && wbStb;
        end
    end

    // range flag lines up with the memory read data
    always_ff @(posedge clk) begin
        outOfRange <= (int'(wbAdr) >= `MEM_DEPTH);
    end

    assign wbDatOut = outOfRange ? instrT'(`NOP_INSTR) : memRdData;

endmodule

`default_nettype wire

/* source/bootLoaderTop.sv */
`default_nettype none

module bootLoaderTop (
    input  wire logic                   clk,
    input  wire logic                   arstN,
    input  wire logic                   rxSerial,
    output logic                        cpuEnable,
    input  wire logic                   wbCyc,
    input  wire logic                   wbStb,
    input  wire bootLoaderPkg::busAdrT  wbAdr,
    output bootLoaderPkg::instrT        wbDatOut,
    output logic                        wbAck
);
    import bootLoaderPkg::*;

    byteT   rxByte;
    logic   rxValid;
    logic   memWe;
    memIdxT memWrIdx;
    instrT  memWrData;
    memIdxT memRdIdx;
    instrT  memRdData;

    // serial byte source
    uartRx uRx (
        .clk      (clk),
        .arstN    (arstN),
        .rxSerial (rxSerial),
        .rxByte   (rxByte),
        .rxValid  (rxValid)
    );

    // length byte, word packing, processor release
    programLoader uLoader (
        .clk       (clk),
        .arstN     (arstN),
        .rxByte    (rxByte),
        .rxValid   (rxValid),
        .memWe     (memWe),
        .memWrIdx  (memWrIdx),
        .memWrData (memWrData),
        .cpuEnable (cpuEnable)
    );

    instrMem uMem (
        .clk       (clk),
        .memWe     (memWe),
        .memWrIdx  (memWrIdx),
        .memWrData (memWrData),
        .memRdIdx  (memRdIdx),
        .memRdData (memRdData)
    );

    // fetch port toward the processor
    instrBusSlave uBus (
        .clk       (clk),
        .arstN     (arstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbAdr     (wbAdr),
        .wbDatOut  (wbDatOut),
        .wbAck     (wbAck),
        .memRdIdx  (memRdIdx),
        .memRdData (memRdData)
    );

endmodule

`default_nettype wire

/* bench/bootLoaderTb.sv */
`default_nettype none
`include "bootLoader_consts.svh"

module bootLoaderTb;
    timeunit 1ns;
    timeprecision 100ps;
    import bootLoaderPkg::*;

    localparam int AckTimeout = 20;
    localparam int EnableTimeout = 2 * `CLKS_PER_BIT;

    logic   clk;
    logic   arstN;
    logic   rxSerial;
    logic   cpuEnable;
    logic   wbCyc;
    logic   wbStb;
    busAdrT wbAdr;
    instrT  wbDatOut;
    logic   wbAck;

    // reference copy of the program sent over the line
    instrT  model [`MEM_DEPTH];
    integer seed;
    int     progLen;
    int     badPos;
    instrT  rdWord;
    busAdrT rdAdr;
    byteT   txByte;

    bootLoaderTop dut (
        .clk       (clk),
        .arstN     (arstN),
        .rxSerial  (rxSerial),
        .cpuEnable (cpuEnable),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbAdr     (wbAdr),
        .wbDatOut  (wbDatOut),
        .wbAck     (wbAck)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic checkInstr(input string name, input instrT expVal, input instrT actVal);
        if (expVal !== actVal) begin
            $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (expVal !== actVal) begin
            $display("[FAIL] %s expected %h actual %h", name, expVal, actVal);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // one bit time, leaves the caller at the next drive point
    task automatic driveBit(input logic level);
        rxSerial = level;
        repeat (`CLKS_PER_BIT) @(posedge clk);
        #2;
    endtask

    // start bit and eight data bits, lsb first
    task automatic sendData(input byteT data);
        driveBit(1'b0);
        for (int b = 0; b < 8; b++) begin
            driveBit(data[b]);
        end
    endtask

    // a low stop bit is followed by one idle bit so the next start edge is clean
    task automatic sendStop(input logic level);
        driveBit(level);
        if (!level) begin
            driveBit(1'b1);
        end
    endtask

    task automatic sendByte(input byteT data);
        sendData(data);
        sendStop(1'b1);
    endtask

    task automatic waitEnable();
        int cnt;
        cnt = 0;
        while (cpuEnable !== 1'b1) begin
            if (cnt >= EnableTimeout) begin
                reportTimeout("cpuEnable to rise after the last stop bit");
            end
            @(posedge clk);
            #2;
            cnt++;
        end
    endtask

    // classic read, request held until ack, then ack must stay low
    task automatic readWord(input busAdrT adr, output instrT data);
        int cnt;
        cnt = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbAdr = adr;
        do begin
            if (cnt >= AckTimeout) begin
                reportTimeout("wbAck on a fetch read");
            end
            @(posedge clk);
            #2;
            cnt++;
        end while (wbAck !== 1'b1);
        data = wbDatOut;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
            checkFlag("wbAck", 1'b0, wbAck);
        end
    endtask

    task automatic readProgram();
        for (int i = 0; i < progLen; i++) begin
            rdAdr = busAdrT'(i);
            readWord(rdAdr, rdWord);
            checkInstr($sformatf("wbDatOut[%h]", rdAdr), model[i], rdWord);
        end
    endtask

    initial begin
        seed     = 84526;
        arstN    = 1'b0;
        rxSerial = 1'b1;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbAdr    = '0;
        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;
        checkFlag("cpuEnable", 1'b0, cpuEnable);
        checkFlag("wbAck", 1'b0, wbAck);
        repeat (5) @(posedge clk);
        #2;

        // random program of 1 to 24 words
        progLen = 1 + ($unsigned($random(seed)) % 24);
        for (int i = 0; i < progLen; i++) begin
            model[i] = instrT'($random(seed));
        end
        // framing-error frame lands between two good program bytes
        badPos = 1 + ($unsigned($random(seed)) % (4 * progLen - 1));

        sendByte(byteT'(progLen));
        for (int i = 0; i < 4 * progLen; i++) begin
            if (i == badPos) begin
                sendData(byteT'($random(seed)));
                sendStop(1'b0);
            end
            txByte = byteT'(model[i / 4] >> (8 * (3 - (i % 4))));
            if (i == 4 * progLen - 1) begin
                sendData(txByte);
                checkFlag("cpuEnable", 1'b0, cpuEnable);
                sendStop(1'b1);
            end else begin
                sendByte(txByte);
            end
        end
        waitEnable();

        readProgram();

        // fetches past the store return the NOP word
        for (int i = 0; i < 16; i++) begin
            rdAdr = busAdrT'(`MEM_DEPTH + ($unsigned($random(seed)) % 128));
            readWord(rdAdr, rdWord);
            checkInstr($sformatf("wbDatOut[%h]", rdAdr), instrT'(`NOP_INSTR), rdWord);
        end

        // trailing bytes after the program are ignored
        for (int i = 0; i < 6; i++) begin
            sendByte(byteT'($random(seed)));
            checkFlag("cpuEnable", 1'b1, cpuEnable);
        end
        readProgram();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bootLoader.f */
+incdir+include
source/bootLoaderPkg.sv
source/uartRx.sv
source/programLoader.sv
source/instrMem.sv
source/instrBusSlave.sv
source/bootLoaderTop.sv
bench/bootLoaderTb.sv
